//--- cache.f
+incdir+src
src/cache_pkg.sv
src/cache_ctrl.sv
src/cache_tag_store.sv
src/cache_data_store.sv
src/cache.sv
sim/cache_chk.sv
sim/cache_tb.sv

//--- sim/cache_chk.sv
module cache_chk import cache_pkg::*; (
        input logic  clk,
        input logic  resetn,
        input logic  valid,
        input logic  addr_ok,
        input logic  data_ok,
        input logic  rd_req,
        input logic  rd_rdy,
        input word_t rd_addr,
        input logic  wr_req,
        input logic  wr_rdy
);

        timeunit 1ns;
        timeprecision 1ps;

        logic [1:0]  pending;   // accepted but not yet answered
        int unsigned err_cnt = 0;

        always_ff @(posedge clk) begin
                if (!resetn)
                        pending <= '0;
                else
                        pending <= pending + 2'(valid && addr_ok) - 2'(data_ok);
        end

        a_data_ok: assert property (@(posedge clk) disable iff (!resetn)
                data_ok |-> pending != 2'd0)
                else begin
                        err_cnt++;
                        $error("data_ok with no request outstanding");
                end

        a_rd_hold: assert property (@(posedge clk) disable iff (!resetn)
                rd_req && !rd_rdy |=> rd_req)
                else begin
                        err_cnt++;
                        $error("rd_req dropped before rd_rdy");
                end

        a_wr_hold: assert property (@(posedge clk) disable iff (!resetn)
                wr_req && !wr_rdy |=> wr_req)
                else begin
                        err_cnt++;
                        $error("wr_req dropped before wr_rdy");
                end

        // line refills always start at word 0
        a_rd_align: assert property (@(posedge clk) disable iff (!resetn)
                rd_req |-> rd_addr[3:0] == 4'h0)
                else begin
                        err_cnt++;
                        $error("rd_addr not line aligned");
                end

endmodule

//--- sim/cache_golden.txt
# name op addr wstrb wdata exp_rdata exp_wb_addr (hex fields, op 1 = store)
# exp_rdata is ignored for stores, exp_wb_addr 0 means no writeback
ld_miss_first      0 00012348 0 00000000 5a5b86ed 00000000
ld_hit_same_line   0 00012344 0 00000000 5a5b86e1 00000000
st_hit_partial     1 00012344 3 deadbeef 00000000 00000000
ld_after_store     0 00012344 0 00000000 5a5bbeef 00000000
st_miss_merge      1 0000567c c 12345678 00000000 00000000
ld_after_st_miss   0 0000567c 0 00000000 1234f3d9 00000000
set_load_b         0 00077340 0 00000000 5a5dd6e5 00000000
set_load_c_evict   0 0009934c 0 00000000 5a5336e9 00012340
reload_evicted     0 00012344 0 00000000 5a5bbeef 00000000
reload_hit         0 00012348 0 00000000 5a5b86ed 00000000
st_miss_way1       1 0000a670 f cafef00d 00000000 00000000
st_miss_evict      1 0000b674 1 00000042 00000000 00005670
ld_st_evict_line   0 0000b674 0 00000000 5a5a1342 00000000
ld_written_back    0 0000567c 0 00000000 1234f3d9 0000a670
ld_store_line      0 0000a670 0 00000000 cafef00d 0000b670

//--- sim/cache_tb.sv
`include "cache_cfg.svh"

module cache_tb import cache_pkg::*; ();

        timeunit 1ns;
        timeprecision 1ps;

        logic        clk, resetn;
        logic        valid, op;
        index_t      index;
        tag_t        tag;
        offset_t     offset;
        strb_t       wstrb;
        word_t       wdata;
        logic        addr_ok, data_ok;
        word_t       rdata;
        logic        rd_req, rd_rdy, ret_valid, ret_last;
        logic [2:0]  rd_type, wr_type;
        word_t       rd_addr, ret_data, wr_addr;
        logic        wr_req, wr_rdy;
        strb_t       wr_wstrb;
        line_t       wr_data;

        string       g_name [$];
        logic        g_op [$];
        strb_t       g_strb [$];
        word_t       g_addr [$], g_wdata [$], g_rdata [$], g_wb [$];
        bit          loaded = 1'b0;

        word_t       mem_model [word_t];   // lines the cache wrote back
        word_t       shadow [word_t];      // all cpu stores so far
        word_t       line_mru [int];       // resident lines per set
        word_t       line_lru [int];
        string       cur_name = "reset";
        word_t       cur_addr = '0;
        word_t       wb_seen = '0;
        int          rd_cnt = 0;
        bit          exp_read = 1'b0;

        cache cache_inst (.*);

        bind cache cache_chk chk_inst (.*);

        function automatic word_t model_word(word_t a);
                return mem_model.exists(a) ? mem_model[a] : a ^ 32'h5a5a_a5a5;
        endfunction

        function automatic word_t arch_word(word_t a);
                return shadow.exists(a) ? shadow[a] : model_word(a);
        endfunction

        function automatic word_t merge_bytes(word_t old, strb_t strb, word_t data);
                word_t w;
                w = old;
                for (int i = 0; i < 4; i++)
                        if (strb[i])
                                w[8*i +: 8] = data[8*i +: 8];
                return w;
        endfunction

        function automatic line_t tracked_line(word_t base);
                line_t l;
                for (int i = 0; i < `CACHE_BANKS; i++)
                        l[32*i +: 32] = arch_word(base + 32'(4*i));
                return l;
        endfunction

        // 1 when the line is resident, then it becomes the most recent one
        function automatic bit touch_line(word_t line);
                int set;
                bit resident;
                set      = int'(line[`CACHE_OFFSET_W +: `CACHE_INDEX_W]);
                resident = 1'b1;
                if (line_lru.exists(set) && line_lru[set] == line) begin
                        line_lru[set] = line_mru[set];
                        line_mru[set] = line;
                end else if (!line_mru.exists(set) || line_mru[set] != line) begin
                        resident = 1'b0;
                        if (line_mru.exists(set))
                                line_lru[set] = line_mru[set];
                        line_mru[set] = line;
                end
                return resident;
        endfunction

        task automatic check_word(string name, word_t expected, word_t actual);
                if (expected !== actual) begin
                        $display("Fail %s: expected %h, actual %h", name, expected, actual);
                        $display("test failed");
                        $fatal(1, "data mismatch");
                end
        endtask

        task automatic check_addr(string name, word_t expected, word_t actual);
                if (expected !== actual) begin
                        $display("Fail %s: expected %h, actual %h", name, expected, actual);
                        $display("test failed");
                        $fatal(1, "address mismatch");
                end
        endtask

        task automatic check_line(string name, line_t expected, line_t actual);
                if (expected !== actual) begin
                        $display("Fail %s: expected %h, actual %h", name, expected, actual);
                        $display("test failed");
                        $fatal(1, "writeback line mismatch");
                end
        endtask

        // writeback address and number of line reads of a drained request
        task automatic check_bridge(int k);
                check_addr(g_name[k], g_wb[k], wb_seen);
                check_word(g_name[k], word_t'(exp_read), word_t'(rd_cnt));
        endtask

        task automatic load_golden();
                int    fd;
                int    op_i;
                string row;
                string nm;
                word_t a, s, d, r, w;
                fd = $fopen("sim/cache_golden.txt", "r");
                if (fd == 0) begin
                        $display("cannot open sim/cache_golden.txt");
                        $display("test failed");
                        $fatal(1, "no stimulus");
                end else begin
                        while ($fgets(row, fd) > 0) begin
                                if (row[0] != "#" && $sscanf(row, "%s %d %h %h %h %h %h",
                                                nm, op_i, a, s, d, r, w) == 7) begin
                                        g_name.push_back(nm);
                                        g_op.push_back(op_i[0]);
                                        g_addr.push_back(a);
                                        g_strb.push_back(s[3:0]);
                                        g_wdata.push_back(d);
                                        g_rdata.push_back(r);
                                        g_wb.push_back(w);
                                end
                        end
                        $fclose(fd);
                        loaded = 1'b1;
                end
        endtask

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        initial begin
                wait (loaded);
                repeat (200 * g_name.size() + 20) @(posedge clk);
                $display("timeout waiting for data_ok");
                $display("test failed");
                $fatal(1, "watchdog expired");
        end

        initial begin
                wait (cache_inst.chk_inst.err_cnt != 0);
                $display("handshake assertion failed");
                $display("test failed");
                $fatal(1, "assertion error");
        end

        // bridge model, random ready delay then four beats back to back
        initial begin
                word_t base;
                rd_rdy    = 1'b0;
                ret_valid = 1'b0;
                ret_last  = 1'b0;
                ret_data  = '0;
                wr_rdy    = 1'b0;
                void'($urandom(32'h06a3_05fe));
                forever begin
                        @(negedge clk);
                        if (wr_req) begin
                                check_word(cur_name, word_t'({`CACHE_WR_LINE, 4'hf}),
                                           word_t'({wr_type, wr_wstrb}));
                                repeat ($urandom % 4) @(posedge clk);
                                @(posedge clk);
                                #1 wr_rdy = 1'b1;
                                @(negedge clk);
                                wb_seen = wr_addr;
                                check_line(cur_name, tracked_line(wr_addr), wr_data);
                                for (int i = 0; i < `CACHE_BANKS; i++)
                                        mem_model[wr_addr + 32'(4*i)] = wr_data[32*i +: 32];
                                @(posedge clk);
                                #1 wr_rdy = 1'b0;
                        end else if (rd_req) begin
                                check_addr(cur_name, {cur_addr[31:4], 4'h0}, rd_addr);
                                check_word(cur_name, word_t'(`CACHE_RD_LINE), word_t'(rd_type));
                                rd_cnt++;
                                base = rd_addr;
                                repeat ($urandom % 4) @(posedge clk);
                                @(posedge clk);
                                #1 rd_rdy = 1'b1;
                                @(posedge clk);
                                #1 rd_rdy = 1'b0;
                                for (int i = 0; i < `CACHE_BANKS; i++) begin
                                        ret_valid = 1'b1;
                                        ret_last  = i == `CACHE_BANKS - 1;
                                        ret_data  = model_word(base + 32'(4*i));
                                        @(posedge clk);
                                        #1;
                                end
                                ret_valid = 1'b0;
                                ret_last  = 1'b0;
                        end
                end
        end

        initial begin
                bit stall_exp;
                resetn = 1'b0;
                valid  = 1'b0;
                op     = 1'b0;
                index  = '0;
                tag    = '0;
                offset = '0;
                wstrb  = '0;
                wdata  = '0;
                load_golden();
                repeat (5) @(posedge clk);
                #1 resetn = 1'b1;
                @(negedge clk);
                // addr_ok, data_ok, rd_req, wr_req
                check_word("reset", 32'h8, word_t'({addr_ok, data_ok, rd_req, wr_req}));
                for (int k = 0; k < g_name.size(); k++) begin
                        // a load right behind a store hit meets the buffer write in its bank
                        stall_exp = k > 0 && g_op[k-1] && !exp_read && !g_op[k]
                                 && g_addr[k][3:2] == g_addr[k-1][3:2];
                        @(posedge clk);
                        #1;
                        valid = 1'b1;
                        op    = g_op[k];
                        {tag, index, offset} = g_addr[k];
                        wstrb = g_strb[k];
                        wdata = g_wdata[k];
                        @(negedge clk);
                        if (stall_exp)
                                check_word(g_name[k], 32'h0, word_t'(addr_ok));
                        while (!addr_ok)
                                @(negedge clk);
                        @(posedge clk);
                        #1 valid = 1'b0;
                        // previous request has fully drained once this one is taken
                        if (k > 0)
                                check_bridge(k - 1);
                        wb_seen  = '0;
                        rd_cnt   = 0;
                        exp_read = !touch_line(g_addr[k] & ~32'hf);
                        cur_name = g_name[k];
                        cur_addr = g_addr[k];
                        if (g_op[k])
                                shadow[g_addr[k] & ~32'h3] = merge_bytes(
                                        arch_word(g_addr[k] & ~32'h3), g_strb[k], g_wdata[k]);
                        do @(negedge clk); while (!data_ok);
                        if (!g_op[k])
                                check_word(g_name[k], g_rdata[k], rdata);
                end
                do @(negedge clk); while (!addr_ok);
                check_bridge(g_name.size() - 1);
                if (cache_inst.chk_inst.err_cnt == 0) begin
                        $display("test passed");
                        $finish;
                end else begin
                        $display("test failed");
                        $fatal(1, "handshake assertions fired");
                end
        end

endmodule

//--- src/cache.sv
module cache import cache_pkg::*; (
        input  logic        clk,
        input  logic        resetn,
        // cpu side
        input  logic        valid,
        input  logic        op,         // 1 = store
        input  index_t      index,
        input  tag_t        tag,
        input  offset_t     offset,
        input  strb_t       wstrb,
        input  word_t       wdata,
        output logic        addr_ok,
        output logic        data_ok,
        output word_t       rdata,
        // bridge side
        output logic        rd_req,
        output logic [2:0]  rd_type,
        output word_t       rd_addr,
        input  logic        rd_rdy,
        input  logic        ret_valid,
        input  logic        ret_last,
        input  word_t       ret_data,
        output logic        wr_req,
        output logic [2:0]  wr_type,
        output word_t       wr_addr,
        output strb_t       wr_wstrb,
        output line_t       wr_data,
        input  logic        wr_rdy
);

        logic   look_en;
        index_t look_index;
        bank_t  look_bank;
        tag_t   req_tag;
        logic   refill_we;
        bank_t  refill_beat;
        word_t  refill_word;
        logic   wb_we;
        logic   wb_way;
        bank_t  wb_bank;
        index_t wb_index;
        strb_t  wb_strb;
        word_t  wb_data;
        logic   hit;
        logic   hit_way;
        logic   victim_way;
        logic   victim_dirty;
        tag_t   victim_tag;

        cache_ctrl ctrl_inst (.*);

        // look_index holds the request index once it is accepted
        cache_tag_store tag_store_inst (
                .clk, .resetn, .look_en, .look_index, .req_tag, .refill_we,
                .refill_index (look_index), .refill_tag (req_tag),
                .wb_we, .wb_way, .wb_index,
                .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
        );

        cache_data_store data_store_inst (
                .clk, .look_en, .look_index, .look_bank, .refill_we,
                .refill_way (victim_way), .refill_beat, .refill_word,
                .wb_we, .wb_way, .wb_bank, .wb_index, .wb_strb, .wb_data, .hit_way,
                .load_word (rdata), .victim_line (wr_data)
        );

endmodule

//--- src/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// address split for 256 sets of 16-byte lines
`define CACHE_TAG_W     20
`define CACHE_INDEX_W   8
`define CACHE_OFFSET_W  4

`define CACHE_WAYS      2
`define CACHE_BANKS     4   // 32-bit words per line
`define CACHE_SETS      256

`define CACHE_LINE_W    128

// bridge type codes, whole line transfer
`define CACHE_RD_LINE   3'd4
`define CACHE_WR_LINE   3'd4

`endif

//--- src/cache_ctrl.sv
`include "cache_cfg.svh"

module cache_ctrl import cache_pkg::*; (
        input  logic        clk,
        input  logic        resetn,
        input  logic        valid,
        input  logic        op,
        input  index_t      index,
        input  tag_t        tag,
        input  offset_t     offset,
        input  strb_t       wstrb,
        input  word_t       wdata,
        output logic        addr_ok,
        output logic        data_ok,
        output logic        rd_req,
        output logic [2:0]  rd_type,
        output word_t       rd_addr,
        input  logic        rd_rdy,
        input  logic        ret_valid,
        input  logic        ret_last,
        input  word_t       ret_data,
        output logic        wr_req,
        output logic [2:0]  wr_type,
        output word_t       wr_addr,
        output strb_t       wr_wstrb,
        input  logic        wr_rdy,
        output logic        look_en,
        output index_t      look_index,
        output bank_t       look_bank,
        output tag_t        req_tag,
        output logic        refill_we,
        output bank_t       refill_beat,
        output word_t       refill_word,
        output logic        wb_we,
        output logic        wb_way,
        output bank_t       wb_bank,
        output index_t      wb_index,
        output strb_t       wb_strb,
        output word_t       wb_data,
        input  logic        hit,
        input  logic        hit_way,
        input  logic        victim_way,
        input  logic        victim_dirty,
        input  tag_t        victim_tag
);

        ctrl_state_e state_q, state_d;
        cache_addr_u req_q, rd_line, wr_line;
        logic        reg_op;
        strb_t       reg_wstrb;
        word_t       reg_wdata;
        bank_t       req_bank;
        bank_t       cnt_q;
        logic        stall;
        logic        wb_load;

        // banks are single ported, a load waits out the buffer write
        assign stall   = valid && !op && wb_we && offset[3:2] == wb_bank;
        assign addr_ok = state_q == IDLE && !stall;
        assign look_en = addr_ok && valid;

        assign look_index = (state_q == IDLE) ? index : req_q.f.index;
        assign look_bank  = offset[3:2];
        assign req_tag    = req_q.f.tag;
        assign req_bank   = req_q.f.offset[3:2];

        always_ff @(posedge clk) begin
                if (look_en) begin
                        req_q.f.tag    <= tag;
                        req_q.f.index  <= index;
                        req_q.f.offset <= offset;
                        reg_op         <= op;
                        reg_wstrb      <= wstrb;
                        reg_wdata      <= wdata;
                end
        end

        always_ff @(posedge clk) begin
                if (!resetn)
                        state_q <= IDLE;
                else
                        state_q <= state_d;
        end

        always_comb begin
                state_d = state_q;
                unique case (state_q)
                        IDLE:    if (look_en) state_d = LOOKUP;
                        LOOKUP:  state_d = hit ? IDLE : MISS;
                        MISS:    if (!victim_dirty || wr_rdy) state_d = REPLACE;
                        REPLACE: if (rd_rdy) state_d = REFILL;
                        REFILL:  if (ret_valid && ret_last) state_d = IDLE;
                        default: state_d = IDLE;
                endcase
        end

        always_ff @(posedge clk) begin
                if (!resetn)
                        cnt_q <= '0;
                else if (refill_we)
                        cnt_q <= ret_last ? bank_t'(0) : cnt_q + 2'd1;
        end

        assign refill_we   = state_q == REFILL && ret_valid;
        assign refill_beat = cnt_q;

        // store miss: new bytes over the returned word
        always_comb begin
                refill_word = ret_data;
                if (reg_op && cnt_q == req_bank) begin
                        for (int i = 0; i < 4; i++) begin
                                if (reg_wstrb[i])
                                        refill_word[8*i +: 8] = reg_wdata[8*i +: 8];
                        end
                end
        end

        // store hits, and store misses once the line is in, which marks it dirty
        assign wb_load = state_q == LOOKUP && reg_op && hit
                      || refill_we && ret_last && reg_op;

        always_ff @(posedge clk) begin
                if (!resetn)
                        wb_we <= 1'b0;
                else
                        wb_we <= wb_load;
        end

        always_ff @(posedge clk) begin
                if (wb_load) begin
                        wb_way   <= (state_q == LOOKUP) ? hit_way : victim_way;
                        wb_bank  <= req_bank;
                        wb_index <= req_q.f.index;
                        wb_strb  <= reg_wstrb;
                        wb_data  <= reg_wdata;
                end
        end

        assign data_ok = state_q == LOOKUP && (reg_op || hit)
                      || refill_we && !reg_op && cnt_q == req_bank;

        always_comb begin
                rd_line          = req_q;
                rd_line.f.offset = '0;
                wr_line          = rd_line;
                wr_line.f.tag    = victim_tag;
        end

        assign rd_req   = state_q == REPLACE;
        assign rd_type  = `CACHE_RD_LINE;
        assign rd_addr  = rd_line.flat;
        assign wr_req   = state_q == MISS && victim_dirty;
        assign wr_type  = `CACHE_WR_LINE;
        assign wr_addr  = wr_line.flat;
        assign wr_wstrb = 4'hf;

endmodule

//--- src/cache_data_store.sv
`include "cache_cfg.svh"

module cache_data_store import cache_pkg::*; (
        input  logic   clk,
        input  logic   look_en,
        input  index_t look_index,
        input  bank_t  look_bank,
        input  logic   refill_we,
        input  logic   refill_way,
        input  bank_t  refill_beat,
        input  word_t  refill_word,
        input  logic   wb_we,
        input  logic   wb_way,
        input  bank_t  wb_bank,
        input  index_t wb_index,
        input  strb_t  wb_strb,
        input  word_t  wb_data,
        input  logic   hit_way,
        output word_t  load_word,
        output line_t  victim_line
);

        word_t  bank_rd [`CACHE_WAYS][`CACHE_BANKS];
        index_t idx_q;
        bank_t  bank_q;

        // registered read address
        always_ff @(posedge clk) begin
                if (look_en) begin
                        idx_q  <= look_index;
                        bank_q <= look_bank;
                end
        end

        for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
                for (genvar b = 0; b < `CACHE_BANKS; b++) begin : g_bank
                        word_t mem [`CACHE_SETS];
                        logic  fill_sel;
                        logic  wb_sel;

                        assign fill_sel = refill_we && refill_way == 1'(w) && refill_beat == bank_t'(b);
                        assign wb_sel   = wb_we && wb_way == 1'(w) && wb_bank == bank_t'(b);

                        always_ff @(posedge clk) begin
                                for (int i = 0; i < 4; i++) begin
                                        if (wb_sel && wb_strb[i])
                                                mem[wb_index][8*i +: 8] <= wb_data[8*i +: 8];
                                        else if (fill_sel)
                                                mem[idx_q][8*i +: 8] <= refill_word[8*i +: 8];
                                end
                        end

                        assign bank_rd[w][b] = mem[idx_q];
                end
        end

        // a load miss takes its word straight from the bridge beat
        assign load_word = (refill_we && refill_beat == bank_q) ? refill_word
                                                                 : bank_rd[hit_way][bank_q];

        assign victim_line = {bank_rd[refill_way][3], bank_rd[refill_way][2],
                              bank_rd[refill_way][1], bank_rd[refill_way][0]};

endmodule

//--- src/cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

        typedef logic [`CACHE_TAG_W-1:0]    tag_t;
        typedef logic [`CACHE_INDEX_W-1:0]  index_t;
        typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

        typedef logic [31:0]                word_t;
        typedef logic [3:0]                 strb_t;
        typedef logic [`CACHE_LINE_W-1:0]   line_t;
        typedef logic [$clog2(`CACHE_BANKS)-1:0] bank_t;   // offset[3:2]

        typedef struct packed {
                tag_t    tag;
                index_t  index;
                offset_t offset;
        } cache_addr_s;

        // flat view for the bridge, field view for lookup
        typedef union packed {
                word_t       flat;
                cache_addr_s f;
        } cache_addr_u;

        typedef enum logic [4:0] {
                IDLE    = 5'b00001,
                LOOKUP  = 5'b00010,
                MISS    = 5'b00100,
                REPLACE = 5'b01000,
                REFILL  = 5'b10000
        } ctrl_state_e;

endpackage

//--- src/cache_tag_store.sv
`include "cache_cfg.svh"

module cache_tag_store import cache_pkg::*; (
        input  logic   clk,
        input  logic   resetn,
        input  logic   look_en,
        input  index_t look_index,
        input  tag_t   req_tag,
        input  logic   refill_we,
        input  index_t refill_index,
        input  tag_t   refill_tag,
        input  logic   wb_we,
        input  logic   wb_way,
        input  index_t wb_index,
        output logic   hit,
        output logic   hit_way,
        output logic   victim_way,
        output logic   victim_dirty,
        output tag_t   victim_tag
);

        logic [`CACHE_TAG_W:0]   tagv [`CACHE_WAYS][`CACHE_SETS];  // {tag, valid}
        logic [`CACHE_SETS-1:0]  dirty [`CACHE_WAYS];
        logic [`CACHE_SETS-1:0]  lru;       // way not used last
        logic [`CACHE_WAYS-1:0]  way_hit;
        index_t                  idx_q;
        logic                    lookup_q;
        logic                    victim_q;

        always_ff @(posedge clk) begin
                if (look_en)
                        idx_q <= look_index;
        end

        always_ff @(posedge clk) begin
                if (!resetn) begin
                        for (int w = 0; w < `CACHE_WAYS; w++) begin
                                for (int s = 0; s < `CACHE_SETS; s++)
                                        tagv[w][s][0] <= 1'b0;
                        end
                end else if (refill_we) begin
                        tagv[victim_q][refill_index] <= {refill_tag, 1'b1};
                end
        end

        always_ff @(posedge clk) begin
                if (!resetn) begin
                        lookup_q <= 1'b0;
                        victim_q <= 1'b0;
                        lru      <= '0;
                        for (int w = 0; w < `CACHE_WAYS; w++)
                                dirty[w] <= '0;
                end else begin
                        lookup_q <= look_en;
                        if (look_en)
                                victim_q <= lru[look_index];   // held through the refill
                        if (lookup_q && hit)
                                lru[idx_q] <= ~hit_way;
                        else if (refill_we)
                                lru[refill_index] <= ~victim_q;
                        if (wb_we)
                                dirty[wb_way][wb_index] <= 1'b1;
                        else if (refill_we)
                                dirty[victim_q][refill_index] <= 1'b0;
                end
        end

        always_comb begin
                for (int w = 0; w < `CACHE_WAYS; w++)
                        way_hit[w] = tagv[w][idx_q][0] && tagv[w][idx_q][`CACHE_TAG_W:1] == req_tag;
        end

        assign hit          = |way_hit;
        assign hit_way      = way_hit[1];
        assign victim_way   = victim_q;
        assign victim_dirty = dirty[victim_q][idx_q] && tagv[victim_q][idx_q][0];
        assign victim_tag   = tagv[victim_q][idx_q][`CACHE_TAG_W:1];

endmodule
